/* list.f */
+incdir+.
squash_pkg.sv
seq_age.sv
squash_select.sv
squash_unit.sv
tb_squash_unit.sv

/* Makefile */
# Verilator build and run for the squash arbiter

VERILATOR ?= verilator
TB_TOP    ?= tb_squash_unit
RTL_TOP   ?= squash_unit
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert

SIM_BIN   := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# Pass only if the pass message stands alone on a line of the log
run: build
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -f $(FILELIST) --top-module $(RTL_TOP) \
	  squash_pkg.sv seq_age.sv squash_select.sv squash_unit.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_squash_unit.sv */
/*
 * Testbench for the squash arbiter top level
 * Xorshift stimulus, reference oldest-pick model, comparing process
 */

`timescale 1ns/10ps

`include "squash_settings.svh"

module tb_squash_unit import squash_pkg::*; ();

  localparam int n_req = `SQ_NUM_REQ;

  logic        clk;
  logic        rst_n;
  commit_msg_t commit;
  squash_req_t req [n_req];
  squash_req_t gnt;

  logic [31:0] rng_state;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          test_err_base;
  string       test_name;

  // Reference model of the committed point and the grant due next
  seq_t        model_pt;
  squash_req_t exp_gnt;
  logic        exp_ready;

  squash_unit u_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .commit (commit),
    .req    (req),
    .gnt    (gnt)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] rand_next();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Age = (seq - committed - 1) mod 2**bits; smaller age wins, first index on a tie
  function automatic squash_req_t oldest_request(input squash_req_t r [n_req], input seq_t pt);
    squash_req_t best;
    int          range;
    int          age_i;
    int          best_age;
    range    = 1 << `SQ_SEQ_BITS;
    best     = '0;
    best_age = range;
    for (int i = 0; i < n_req; i++) begin
      if (r[i].valid) begin
        age_i = (int'(r[i].seq_num) - int'(pt) - 1 + 2 * range) % range;
        if (age_i < best_age) begin
          best     = r[i];
          best_age = age_i;
        end
      end
    end
    return best;
  endfunction

  // Stimulus tasks only schedule NBAs, the caller picks the edge
  task automatic clear_inputs();
    commit.valid <= 1'b0;
    for (int i = 0; i < n_req; i++) begin
      req[i].valid <= 1'b0;
    end
  endtask

  task automatic drive_req(input int i, input seq_t seq, input logic [31:0] target);
    req[i].valid   <= 1'b1;
    req[i].seq_num <= seq;
    req[i].target  <= target;
  endtask

  task automatic drive_commit(input seq_t seq);
    commit.valid   <= 1'b1;
    commit.seq_num <= seq;
    commit.pc      <= rand_next();
    commit.waddr   <= 5'(rand_next());
    commit.wdata   <= rand_next();
    commit.wen     <= 1'(rand_next());
  endtask

  task automatic wait_for_grant(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (gnt.valid !== 1'b1 && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (gnt.valid !== 1'b1) begin
      $display("timeout: no grant seen within %0d cycles", max_cycles);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = errors;
  endtask

  // Drain two idle cycles so the comparator sees the last stimulus
  task automatic end_test();
    @(posedge clk);
    clear_inputs();
    @(posedge clk);
    clear_inputs();
    @(negedge clk);
    tests_run++;
    if (errors == test_err_base) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", test_name, errors - test_err_base);
    end
  endtask

  // --------------------
  // Comparator
  // --------------------

  // Check last cycle's prediction, then predict from this cycle's inputs
  always @(negedge clk) begin
    if (exp_ready) begin
      if (gnt.valid !== exp_gnt.valid) begin
        $display("** Error: gnt.valid expected 0x%h got 0x%h", exp_gnt.valid, gnt.valid);
        errors++;
      end else if (exp_gnt.valid) begin
        if (gnt.seq_num !== exp_gnt.seq_num) begin
          $display("** Error: gnt.seq_num expected 0x%h got 0x%h",
                   exp_gnt.seq_num, gnt.seq_num);
          errors++;
        end
        if (gnt.target !== exp_gnt.target) begin
          $display("** Error: gnt.target expected 0x%h got 0x%h", exp_gnt.target, gnt.target);
          errors++;
        end
      end
    end
    if (!rst_n) begin
      exp_gnt  = '0;
      model_pt = '1;
    end else begin
      exp_gnt = oldest_request(req, model_pt);
      // Commit lands after this cycle's requests are judged
      if (commit.valid) begin
        model_pt = commit.seq_num;
      end
    end
    exp_ready = 1'b1;
  end

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    seq_t        base;
    seq_t        step;
    seq_t        top_pt;
    logic [31:0] tgt;
    clk          = 1'b0;
    rst_n        = 1'b0;
    commit       = '0;
    exp_gnt      = '0;
    exp_ready    = 1'b0;
    model_pt     = '1;
    rng_state    = 32'hd51c;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < n_req; i++) begin
      req[i] = '0;
    end

    // No grant in reset or right after
    start_test("reset");
    @(posedge clk);
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (gnt.valid !== 1'b0) begin
      $display("** Error: gnt.valid expected 0x0 got 0x%h", gnt.valid);
      errors++;
    end
    @(negedge clk);
    if (gnt.valid !== 1'b0) begin
      $display("** Error: gnt.valid expected 0x0 got 0x%h", gnt.valid);
      errors++;
    end
    end_test();

    // Lone requester passes through and the strobe then drops
    start_test("single requester");
    for (int i = 0; i < n_req; i++) begin
      base = seq_t'(rand_next());
      tgt  = rand_next();
      @(posedge clk);
      clear_inputs();
      drive_req(i, base, tgt);
      @(posedge clk);
      clear_inputs();
      wait_for_grant(4);
      if (gnt.seq_num !== base) begin
        $display("** Error: gnt.seq_num expected 0x%h got 0x%h", base, gnt.seq_num);
        errors++;
      end
      if (gnt.target !== tgt) begin
        $display("** Error: gnt.target expected 0x%h got 0x%h", tgt, gnt.target);
        errors++;
      end
      @(negedge clk);
      if (gnt.valid !== 1'b0) begin
        $display("** Error: gnt.valid expected 0x0 got 0x%h", gnt.valid);
        errors++;
      end
    end
    end_test();

    // Distinct seqs from an odd stride
    start_test("oldest wins");
    for (int r = 0; r < 8; r++) begin
      @(posedge clk);
      clear_inputs();
      drive_commit(seq_t'(rand_next()));
      base = seq_t'(rand_next());
      step = seq_t'(((rand_next() % 8) << 1) | 1);
      @(posedge clk);
      clear_inputs();
      for (int i = 0; i < n_req; i++) begin
        drive_req(i, seq_t'(base + seq_t'(i) * step), rand_next());
      end
    end
    end_test();

    // Committed point near the top makes small seqs younger
    start_test("wraparound and commit timing");
    top_pt = seq_t'('1) - seq_t'(2);
    @(posedge clk);
    clear_inputs();
    drive_commit(top_pt);
    for (int c = 0; c < 3; c++) begin
      @(posedge clk);
      clear_inputs();
      for (int i = 0; i < n_req; i++) begin
        drive_req(i, seq_t'(top_pt + seq_t'(2) + seq_t'(n_req - 1 - i)), 32'h1000 + i);
      end
      // Retires the oldest request alongside it, must not move this grant
      if (c == 1) begin
        drive_commit(seq_t'(top_pt + seq_t'(2)));
      end
    end
    end_test();

    // Same seq everywhere so the index 0 target wins
    start_test("ties");
    @(posedge clk);
    clear_inputs();
    drive_commit(seq_t'(rand_next()));
    base = seq_t'(rand_next());
    @(posedge clk);
    clear_inputs();
    for (int i = 0; i < n_req; i++) begin
      drive_req(i, base, 32'hcafe_0000 + i);
    end
    @(posedge clk);
    clear_inputs();
    wait_for_grant(4);
    if (gnt.target !== 32'hcafe_0000) begin
      $display("** Error: gnt.target expected 0x%h got 0x%h", 32'hcafe_0000, gnt.target);
      errors++;
    end
    end_test();

    // Everything random
    start_test("random run");
    for (int c = 0; c < 200; c++) begin
      @(posedge clk);
      clear_inputs();
      if ((rand_next() % 4) == 0) begin
        drive_commit(seq_t'(rand_next()));
      end
      for (int i = 0; i < n_req; i++) begin
        if (rand_next() & 1) begin
          drive_req(i, seq_t'(rand_next()), rand_next());
        end
      end
    end
    end_test();

    $display("summary: %0d run, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* squash_unit.sv */
/*
 * Squash arbiter top level
 * Age decode and oldest-select, one cycle from request to grant
 */

`timescale 1ns/10ps

`include "squash_settings.svh"

module squash_unit import squash_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // Retire stream, moves the committed point
  input  commit_msg_t commit,
  // Squash requests from the pipeline units
  input  squash_req_t req [`SQ_NUM_REQ],
  // Oldest request, registered
  output squash_req_t gnt
);

  // --------------------
  // Internal wires
  // --------------------

  // Per-request age, seq_age to squash_select
  age_t age [`SQ_NUM_REQ];

  // --------------------
  // Age decode
  // --------------------

  // Holds the committed point, sees every request
  seq_age u_seq_age (
    .clk    (clk),
    .rst_n  (rst_n),
    .commit (commit),
    .req    (req),
    .age    (age)
  );

  // --------------------
  // Oldest select
  // --------------------

  // Same request array, plus the decoded ages
  squash_select #(
    .num_req (`SQ_NUM_REQ)
  ) u_squash_select (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .age   (age),
    .gnt   (gnt)
  );

endmodule

/* squash_select.sv */
/*
 * Oldest-request select and grant register
 * Linear compare chain on ages, lowest index wins ties
 */

`timescale 1ns/10ps

`include "squash_settings.svh"

module squash_select import squash_pkg::*; #(
  parameter int num_req = `SQ_NUM_REQ
) (
  input  logic        clk,
  input  logic        rst_n,
  // Squash requests, one per unit
  input  squash_req_t req [num_req],
  // Decoded ages, same indexing as req
  input  age_t        age [num_req],
  // Registered winner, one cycle after the requests
  output squash_req_t gnt
);

  localparam int req_bits = $bits(squash_req_t);

  // --------------------
  // Compare chain
  // --------------------

  // One-hot position of the current oldest
  logic [num_req-1:0] win_sel;
  // Age of the current oldest
  age_t               best_age;
  // At least one request this cycle
  logic               any_valid;

  // Walk from index 0 upward
  // Only a strictly smaller age takes over, so a tie keeps the lower index
  always_comb begin
    win_sel   = '0;
    best_age  = '1;
    any_valid = 1'b0;
    for (int i = 0; i < num_req; i++) begin
      if (req[i].valid) begin
        if (!any_valid || (age[i] < best_age)) begin
          // New oldest, drop the previous pick
          win_sel    = '0;
          win_sel[i] = 1'b1;
          best_age   = age[i];
        end
        any_valid = 1'b1;
      end
    end
  end

  // Raw request strobes, taken straight from the ports
  logic [num_req-1:0] req_valid;

  for (genvar i = 0; i < num_req; i++) begin : g_valid
    assign req_valid[i] = req[i].valid;
  end

  // --------------------
  // Winner mux
  // --------------------

  // AND-OR mux on the one-hot select
  logic [req_bits-1:0] winner_bits;
  squash_req_t         winner;

  always_comb begin
    winner_bits = '0;
    for (int i = 0; i < num_req; i++) begin
      winner_bits = winner_bits | (req[i] & {req_bits{win_sel[i]}});
    end
  end

  // All zero when nothing is requested
  assign winner = squash_req_t'(winner_bits);

  // --------------------
  // Grant register
  // --------------------

  // Grant strobe
  logic                       gnt_valid_q;
  // Grant payload
  seq_t                       gnt_seq_q;
  logic [`SQ_TARGET_BITS-1:0] gnt_target_q;

  // High exactly when some request was valid last cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gnt_valid_q <= 1'b0;
    end else begin
      gnt_valid_q <= any_valid;
    end
  end

  // Payload follows the winner every cycle
  always_ff @(posedge clk) begin
    gnt_seq_q    <= winner.seq_num;
    gnt_target_q <= winner.target;
  end

  // Repack into the request layout
  assign gnt.valid   = gnt_valid_q;
  assign gnt.seq_num = gnt_seq_q;
  assign gnt.target  = gnt_target_q;

  // --------------------
  // Checks
  // --------------------

  // A grant only follows a cycle with a live request
  a_gnt_has_source : assert property (
    @(posedge clk) disable iff (!rst_n)
    gnt.valid |-> $past(|req_valid)
  ) else $error("squash_select: grant without a request the cycle before");

  // Chain never picks two winners at once
  a_win_sel_onehot : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(win_sel)
  ) else $error("squash_select: winner select is not one-hot");

endmodule

/* seq_age.sv */
/*
 * Committed point tracking and relative age decode
 * One age per squash request, wrapping sequence arithmetic
 */

`timescale 1ns/10ps

`include "squash_settings.svh"

module seq_age import squash_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // Retire stream from the commit stage
  input  commit_msg_t commit,
  // One entry per requesting unit
  input  squash_req_t req [`SQ_NUM_REQ],
  // Age of each entry relative to the committed point
  output age_t        age [`SQ_NUM_REQ]
);

  // --------------------
  // Committed point
  // --------------------

  // Last retired sequence number
  seq_t commit_pt;

  // All ones out of reset, so seq 0 decodes to age 0
  // New value takes effect the cycle after the commit strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      commit_pt <= '1;
    end else if (commit.valid) begin
      commit_pt <= commit.seq_num;
    end
  end

  // --------------------
  // Age decode
  // --------------------

  // Oldest in-flight instruction is commit_pt + 1
  // age = seq - commit_pt - 1, modulo the sequence range
  // Pure combinational, no dependence on this cycle's commit
  for (genvar i = 0; i < `SQ_NUM_REQ; i++) begin : g_age
    assign age[i] = age_t'(req[i].seq_num - commit_pt - seq_t'(1));
  end

  // --------------------
  // Checks
  // --------------------

  // Committed point stays known once out of reset,
  // an X here would poison every age and the grant after it
  a_commit_pt_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(commit_pt)
  ) else $error("seq_age: committed point is unknown");

endmodule

/* squash_pkg.sv */
/*
 * Shared types for the squash arbiter
 * Sequence number, relative age, squash request, commit message
 */

`include "squash_settings.svh"

package squash_pkg;

  // --------------------
  // Scalar types
  // --------------------

  // Instruction sequence number, wraps around
  typedef logic [`SQ_SEQ_BITS-1:0] seq_t;

  // Distance past the committed point, smaller is older
  typedef logic [`SQ_SEQ_BITS-1:0] age_t;

  // --------------------
  // Squash request
  // --------------------

  // Same layout for a requester's entry and the grant
  typedef struct packed {
    logic                       valid;
    seq_t                       seq_num;
    logic [`SQ_TARGET_BITS-1:0] target;
  } squash_req_t;

  // --------------------
  // Commit notification
  // --------------------

  // Sent by the commit stage once per retired instruction
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    seq_t        seq_num;
    // Register writeback of the retired instruction
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } commit_msg_t;

endpackage

/* squash_settings.svh */
/*
 * Sizing macros for the squash arbiter
 * Requester count, sequence number width, redirect target width
 */

`ifndef SQUASH_SETTINGS_SVH
`define SQUASH_SETTINGS_SVH

// --------------------
// Requesters
// --------------------

// Number of pipeline units that may raise a squash (1 to 16)
`define SQ_NUM_REQ 4

// --------------------
// Field widths
// --------------------

// Sequence number width, ages wrap at 2**SQ_SEQ_BITS
`define SQ_SEQ_BITS 5

// Redirect target, a full address
`define SQ_TARGET_BITS 32

`endif
